/* Bender.yml */
package:
  name: mips_core

sources:
  - common/mipsPkg.sv
  - hdl/mipsControl.sv
  - hdl/regFile.sv
  - hdl/alu.sv
  - hdl/pcUnit.sv
  - hdl/mipsCore.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mipsCoreSva.sv
      - bench/mipsCoreTb.sv

/* bench/mipsCoreSva.sv */
`timescale 1ns/1ns

module mipsCoreSva (
    input logic clk,
    input logic rst_n,
    input logic memCen,
    input logic memWen,
    input logic memOen
);

    // failed assertions so far
    int failCount = 0;

    // rst_n high means reset is applied
    assert property (@(posedge clk) rst_n |-> memCen)
        else begin
            $error("memory enabled during reset");
            failCount++;
        end

    assert property (@(posedge clk) !memWen |-> !memCen)
        else begin
            $error("write enable without chip enable");
            failCount++;
        end

    assert property (@(posedge clk) (!memCen && memWen) |-> !memOen)
        else begin
            $error("read access without output enable");
            failCount++;
        end

endmodule

bind mipsCore mipsCoreSva uSva (
    .clk    (clk),
    .rst_n  (rst_n),
    .memCen (memCen),
    .memWen (memWen),
    .memOen (memOen)
);

/* bench/mipsModel.svh */
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// expected memory port values for one instruction
typedef struct packed {
    logic        known;
    logic [2:0]  wdataCat;
    logic        cen;
    logic        wen;
    logic        oen;
    logic [6:0]  addr;
    logic [31:0] wdata;
} memExpS;

logic [31:0] mRegs [32];
// behaviour number of the instruction that last wrote each register
logic [2:0]  mSrc [32];
logic [31:0] mDmem [128];
logic [31:0] mPc;

task automatic modelReset();
    for (int r = 0; r < 32; r++) begin
        mRegs[r] = '0;
        mSrc[r]  = 3'd2;
    end
    mPc = '0;
endtask

// executes one instruction on the reference state
task automatic modelStep(input instrS ins, output memExpS want);
    logic [31:0] raw;
    logic [31:0] rsV;
    logic [31:0] rtV;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] pc4;
    logic [31:0] nextPc;
    logic [4:0]  dst;
    logic [2:0]  cat;
    raw    = ins;
    rsV    = mRegs[ins.rs];
    rtV    = mRegs[ins.rt];
    imm    = {{16{raw[15]}}, raw[15:0]};
    addr   = rsV + imm;
    pc4    = mPc + 32'd4;
    nextPc = pc4;
    res    = '0;
    dst    = '0;
    cat    = 3'd2;
    want   = '{known: 1'b1, wdataCat: (ins.rt == 5'd0) ? 3'd5 : mSrc[ins.rt],
               cen: 1'b1, wen: 1'b1, oen: 1'b1, addr: addr[8:2], wdata: rtV};
    case (ins.opcode)
        opRType: begin
            dst = ins.rd;
            case (ins.funct)
                fnAdd: res = rsV + rtV;
                fnSub: res = rsV - rtV;
                fnAnd: res = rsV & rtV;
                fnOr:  res = rsV | rtV;
                fnSlt: res = {31'd0, $signed(rsV) < $signed(rtV)};
                fnSll: res = rtV << ins.shamt;
                fnSrl: res = rtV >> ins.shamt;
                fnJr: begin
                    dst    = '0;
                    nextPc = rsV;
                end
                default: begin
                    dst        = '0;
                    want.known = 1'b0;
                end
            endcase
        end
        opAddi: begin
            dst = ins.rt;
            res = addr;
        end
        opLw: begin
            dst      = ins.rt;
            res      = mDmem[addr[8:2]];
            cat      = 3'd3;
            want.cen = 1'b0;
            want.oen = 1'b0;
        end
        opSw: begin
            mDmem[addr[8:2]] = rtV;
            want.cen         = 1'b0;
            want.wen         = 1'b0;
        end
        opBeq, opBne: begin
            // taken on equal for beq, on differ for bne
            if ((rsV == rtV) == (ins.opcode == opBeq)) begin
                nextPc = pc4 + (imm << 2);
            end
        end
        opJ, opJal: begin
            nextPc = {mPc[31:28], raw[25:0], 2'b00};
            if (ins.opcode == opJal) begin
                dst = 5'd31;
                res = pc4;
                cat = 3'd4;
            end
        end
        default: want.known = 1'b0;
    endcase
    if (dst != 5'd0) begin
        mRegs[dst] = res;
        mSrc[dst]  = cat;
    end
    mPc = nextPc;
endtask

`endif

/* bench/mipsCoreTb.sv */
`timescale 1ns/1ns

module mipsCoreTb;
    import mipsPkg::*;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 10;
    localparam int NumCycles   = 2000;
    localparam int ProgDepth   = 256;

    logic                    clk;
    logic                    rst_n;
    instrS                   instr;
    logic [DataWidth-1:0]    memRdata;
    logic [DataWidth-1:0]    instrAddr;
    logic [MemAddrWidth-1:0] memAddr;
    logic [DataWidth-1:0]    memWdata;
    logic                    memCen;
    logic                    memWen;
    logic                    memOen;

    logic [31:0] progMem [ProgDepth];
    logic [31:0] dataMem [128];
    logic [31:0] lfsr = 32'h7aed;
    logic        lastUnknown = 1'b0;
    int          checks [1:5] = '{default: 0};
    int          errors [1:5] = '{default: 0};
    logic [5:0]  aluFns [5] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};

    `include "mipsModel.svh"

    mipsCore i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // data memory with combinational read, written on the rising edge
    assign memRdata = dataMem[memAddr];
    always @(posedge clk) begin
        if (!memCen && !memWen) begin
            dataMem[memAddr] <= memWdata;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // branches and jumps only move forward modulo the memory depth
    task automatic buildProgram();
        logic [3:0]  sel;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int i = 0; i < ProgDepth; i++) begin
            sel = 4'(randBits(4));
            rs  = 5'(randBits(5));
            rt  = 5'(randBits(5));
            rd  = 5'(randBits(5));
            imm = 16'(randBits(16));
            // r30 holds jr targets only
            if (rd == 5'd30) begin
                rd = 5'd0;
            end
            case (sel)
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4: progMem[i] = {6'h00, rs, rt, rd, 5'd0, aluFns[sel]};
                4'd5: progMem[i] = {6'h00, 5'd0, rt, rd, imm[4:0], imm[5] ? fnSrl : fnSll};
                4'd6, 4'd7: progMem[i] = {opAddi, rs, rd, imm};
                4'd8: progMem[i] = {opLw, rs, rd, imm};
                4'd9, 4'd10: progMem[i] = {opSw, rs, rt, imm};
                // few registers so that equal operands occur
                4'd11: progMem[i] = {imm[15] ? opBne : opBeq, 2'b00, rs[2:0], 2'b00, rt[2:0],
                                     13'd0, imm[2:0]};
                4'd12: progMem[i] = {imm[15] ? opJal : opJ, 18'd0, 8'(i + 1 + imm[3:0])};
                4'd13: begin
                    progMem[i] = {opAddi, 5'd0, 5'd30, 6'd0, 8'(i + 2 + imm[2:0]), 2'b00};
                    if (i < ProgDepth - 1) begin
                        i++;
                        progMem[i] = {6'h00, 5'd30, 15'd0, fnJr};
                    end
                end
                4'd14: progMem[i] = imm[15] ? {6'h3f, rs, rt, imm} :
                                              {6'h00, rs, rt, rd, 5'd0, 6'h21};
                // store of r31 or r0
                default: progMem[i] = {opSw, rs, imm[0] ? 5'd31 : 5'd0, imm};
            endcase
        end
        // no memory access right after reset
        progMem[0] = {opAddi, 5'd0, 5'd1, 16'h1234};
    endtask

    task automatic compareValue(input int cat, input string name,
                                input logic [31:0] expVal, input logic [31:0] actVal);
        checks[cat]++;
        if (actVal !== expVal) begin
            errors[cat]++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic checkCycle(input int cycle);
        instrS  ins;
        memExpS want;
        int     flowCat;
        int     memCat;
        ins     = instrS'(progMem[mPc[9:2]]);
        flowCat = (cycle == 0) ? 1 : (lastUnknown ? 5 : 4);
        compareValue(flowCat, "instrAddr", mPc, instrAddr);
        modelStep(ins, want);
        memCat = (cycle == 0) ? 1 : (want.known ? 3 : 5);
        compareValue(memCat, "memCen", want.cen, memCen);
        compareValue(memCat, "memWen", want.wen, memWen);
        compareValue(memCat, "memOen", want.oen, memOen);
        if (!want.cen) begin
            compareValue(3, "memAddr", want.addr, memAddr);
        end
        if (!want.wen) begin
            compareValue(want.wdataCat, "memWdata", want.wdata, memWdata);
        end
        lastUnknown = !want.known;
    endtask

    task automatic report(input int cat, input string name);
        $display("%s: %0d checks, %0d mismatches", name, checks[cat], errors[cat]);
    endtask

    initial begin
        int totalChecks;
        int totalErrors;
        rst_n = 1'b1;
        // a store is held on the bus throughout reset
        instr = instrS'({opSw, 5'd0, 5'd1, 16'd0});
        buildProgram();
        for (int a = 0; a < 128; a++) begin
            dataMem[a] = {4{1'b1, 7'(a)}} ^ 32'h5a3c_c3a5;
            mDmem[a]   = dataMem[a];
        end
        modelReset();
        repeat (ResetCycles) begin
            @(posedge clk);
            #5;
            compareValue(1, "instrAddr", 32'd0, instrAddr);
            compareValue(1, "memCen", 32'd1, memCen);
        end
        for (int c = 0; c < NumCycles; c++) begin
            @(negedge clk);
            rst_n = 1'b0;
            instr = instrS'(progMem[instrAddr[9:2]]);
            #5;
            checkCycle(c);
            if (c == 0) begin
                report(1, "reset");
            end
        end
        report(2, "arithmetic, logic and shift");
        report(3, "loads and stores");
        report(4, "control flow");
        report(5, "register zero and unknown opcodes");
        $display("assertions: %0d failures", i_dut.uSva.failCount);
        totalChecks = 0;
        totalErrors = 0;
        for (int k = 1; k <= 5; k++) begin
            totalChecks += checks[k];
            totalErrors += errors[k];
        end
        totalErrors += i_dut.uSva.failCount;
        $display("total: %0d checks, %0d mismatches", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog at twice the program length
    initial begin
        #(2 * NumCycles * ClkPeriod);
        $display("timeout: the program did not complete in time");
        $display("Errors found");
        $finish;
    end

endmodule

/* build.f */
+incdir+bench
common/mipsPkg.sv
hdl/mipsControl.sv
hdl/regFile.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/mipsCore.sv
bench/mipsCoreSva.sv
bench/mipsCoreTb.sv

/* common/mipsPkg.sv */
package mipsPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int MemAddrWidth = 7;
    localparam int NumRegs      = 2 ** RegAddrWidth;

    // return-address register for jal
    localparam logic [RegAddrWidth-1:0] LinkReg = 5'd31;

    // primary opcodes, MIPS encoding
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    // funct field of R-type
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluSrl
    } aluOpE;

    typedef enum logic [1:0] {
        srcReg,
        srcImm,
        srcShamt
    } srcBE;

    typedef enum logic [1:0] {
        destRt,
        destRd,
        destLink
    } destSelE;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPc4
    } wbSelE;

    // R-type field layout; I and J views overlay the low bits
    typedef struct packed {
        opcodeE                  opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        functE                   funct;
    } instrS;

    typedef struct packed {
        logic    regWrite;
        destSelE destSel;
        wbSelE   wbSel;
        srcBE    srcB;
        aluOpE   aluOp;
        logic    branchEq;
        logic    branchNe;
        logic    jump;
        logic    jumpReg;
        logic    memRead;
        logic    memWrite;
        logic    shiftUsesRt;
    } ctrlS;

    // 16-bit immediate, sign extended
    function automatic logic [DataWidth-1:0] immExt(instrS i);
        return {{16{i.rd[RegAddrWidth-1]}}, i.rd, i.shamt, i.funct};
    endfunction

    // 26-bit jump target field
    function automatic logic [25:0] jumpTarget(instrS i);
        return {i.rs, i.rt, i.rd, i.shamt, i.funct};
    endfunction

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu (
    input  mipsPkg::instrS                instr,
    input  mipsPkg::ctrlS                 ctrl,
    input  logic [mipsPkg::DataWidth-1:0] rdData1,
    input  logic [mipsPkg::DataWidth-1:0] rdData2,
    output logic [mipsPkg::DataWidth-1:0] aluResult,
    output logic                          branchTaken
);
    import mipsPkg::*;

    logic [DataWidth-1:0] opB;
    logic                 opsEqual;

    // operand B select
    always_comb begin
        case (ctrl.srcB)
            srcImm:   opB = immExt(instr);
            srcShamt: opB = DataWidth'(instr.shamt);
            default:  opB = rdData2;
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: begin
                aluResult = rdData1 + opB;
            end
            aluSub: begin
                aluResult = rdData1 - opB;
            end
            aluAnd: begin
                aluResult = rdData1 & opB;
            end
            aluOr: begin
                aluResult = rdData1 | opB;
            end
            aluSlt: begin
                // signed compare
                aluResult = ($signed(rdData1) < $signed(opB)) ? DataWidth'(1) : '0;
            end
            aluSll: begin
                aluResult = rdData1 << opB[4:0];
            end
            aluSrl: begin
                aluResult = rdData1 >> opB[4:0];
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    // branch compare, beq/bne use the register operand
    assign opsEqual    = (rdData1 == opB);
    assign branchTaken = (ctrl.branchEq & opsEqual) | (ctrl.branchNe & ~opsEqual);

endmodule

/* hdl/mipsControl.sv */
`timescale 1ns/1ns

module mipsControl (
    input  logic           rst_n,
    input  mipsPkg::instrS instr,
    output mipsPkg::ctrlS  ctrl,
    output logic           memCen,
    output logic           memWen,
    output logic           memOen
);
    import mipsPkg::*;

    ctrlS dec;

    // main decoder, funct decoded inside the R-type arm
    always_comb begin
        dec = '0;
        case (instr.opcode)
            opRType: begin
                dec.destSel = destRd;
                dec.srcB    = srcReg;
                case (instr.funct)
                    fnAdd: begin
                        dec.regWrite = 1'b1;
                        dec.aluOp    = aluAdd;
                    end
                    fnSub: begin
                        dec.regWrite = 1'b1;
                        dec.aluOp    = aluSub;
                    end
                    fnAnd: begin
                        dec.regWrite = 1'b1;
                        dec.aluOp    = aluAnd;
                    end
                    fnOr: begin
                        dec.regWrite = 1'b1;
                        dec.aluOp    = aluOr;
                    end
                    fnSlt: begin
                        dec.regWrite = 1'b1;
                        dec.aluOp    = aluSlt;
                    end
                    fnSll: begin
                        dec.regWrite    = 1'b1;
                        dec.aluOp       = aluSll;
                        dec.srcB        = srcShamt;
                        dec.shiftUsesRt = 1'b1;
                    end
                    fnSrl: begin
                        dec.regWrite    = 1'b1;
                        dec.aluOp       = aluSrl;
                        dec.srcB        = srcShamt;
                        dec.shiftUsesRt = 1'b1;
                    end
                    fnJr: begin
                        dec.jumpReg = 1'b1;
                    end
                    // unknown funct stays a no-op
                    default: dec = '0;
                endcase
            end
            opAddi: begin
                dec.regWrite = 1'b1;
                dec.srcB     = srcImm;
                dec.aluOp    = aluAdd;
            end
            opLw: begin
                dec.regWrite = 1'b1;
                dec.wbSel    = wbMem;
                dec.srcB     = srcImm;
                dec.aluOp    = aluAdd;
                dec.memRead  = 1'b1;
            end
            opSw: begin
                dec.srcB     = srcImm;
                dec.aluOp    = aluAdd;
                dec.memWrite = 1'b1;
            end
            opBeq: begin
                dec.aluOp    = aluSub;
                dec.branchEq = 1'b1;
            end
            opBne: begin
                dec.aluOp    = aluSub;
                dec.branchNe = 1'b1;
            end
            opJ: begin
                dec.jump = 1'b1;
            end
            opJal: begin
                dec.jump     = 1'b1;
                dec.regWrite = 1'b1;
                dec.destSel  = destLink;
                dec.wbSel    = wbPc4;
            end
            default: dec = '0;
        endcase
    end

    // memory enables are active low
    always_comb begin
        ctrl   = dec;
        memCen = ~(dec.memRead | dec.memWrite);
        memWen = ~dec.memWrite;
        memOen = ~dec.memRead;
        // reset is asserted with rst_n high
        if (rst_n) begin
            ctrl.regWrite = 1'b0;
            memCen        = 1'b1;
            memWen        = 1'b1;
            memOen        = 1'b1;
        end
    end

endmodule

/* hdl/mipsCore.sv */
`timescale 1ns/1ns

module mipsCore (
    input  logic                                clk,
    input  logic                                rst_n,
    input  mipsPkg::instrS                      instr,
    input  logic [mipsPkg::DataWidth-1:0]       memRdata,
    output logic [mipsPkg::DataWidth-1:0]       instrAddr,
    output logic [mipsPkg::MemAddrWidth-1:0]    memAddr,
    output logic [mipsPkg::DataWidth-1:0]       memWdata,
    output logic                                memCen,
    output logic                                memWen,
    output logic                                memOen
);
    import mipsPkg::*;

    ctrlS                 ctrl;
    logic [DataWidth-1:0] rdData1;
    logic [DataWidth-1:0] rdData2;
    logic [DataWidth-1:0] aluResult;
    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] wrData;
    logic                 branchTaken;

    mipsControl uControl (
        .rst_n  (rst_n),
        .instr  (instr),
        .ctrl   (ctrl),
        .memCen (memCen),
        .memWen (memWen),
        .memOen (memOen)
    );

    regFile uRegFile (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .ctrl    (ctrl),
        .wrData  (wrData),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    alu uAlu (
        .instr       (instr),
        .ctrl        (ctrl),
        .rdData1     (rdData1),
        .rdData2     (rdData2),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    pcUnit uPcUnit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .ctrl        (ctrl),
        .branchTaken (branchTaken),
        .rdData1     (rdData1),
        .instrAddr   (instrAddr),
        .pcPlus4     (pcPlus4)
    );

    // write-back select
    assign wrData = (ctrl.wbSel == wbMem) ? memRdata :
                    (ctrl.wbSel == wbPc4) ? pcPlus4  : aluResult;

    // word address into the data memory
    assign memAddr  = aluResult[MemAddrWidth+1:2];
    assign memWdata = rdData2;

endmodule

/* hdl/pcUnit.sv */
`timescale 1ns/1ns

module pcUnit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mipsPkg::instrS                instr,
    input  mipsPkg::ctrlS                 ctrl,
    input  logic                          branchTaken,
    input  logic [mipsPkg::DataWidth-1:0] rdData1,
    output logic [mipsPkg::DataWidth-1:0] instrAddr,
    output logic [mipsPkg::DataWidth-1:0] pcPlus4
);
    import mipsPkg::*;

    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] nextPc;
    logic [DataWidth-1:0] branchAddr;
    logic [DataWidth-1:0] jumpAddr;

    assign instrAddr = pc;
    assign pcPlus4   = pc + DataWidth'(4);

    // word offset relative to the next instruction
    assign branchAddr = pcPlus4 + (immExt(instr) << 2);
    assign jumpAddr   = {pc[DataWidth-1:DataWidth-4], jumpTarget(instr), 2'b00};

    // jump wins over jr, jr over a taken branch
    always_comb begin
        if (ctrl.jump) begin
            nextPc = jumpAddr;
        end else if (ctrl.jumpReg) begin
            nextPc = rdData1;
        end else if (branchTaken) begin
            nextPc = branchAddr;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mipsPkg::instrS                instr,
    input  mipsPkg::ctrlS                 ctrl,
    input  logic [mipsPkg::DataWidth-1:0] wrData,
    output logic [mipsPkg::DataWidth-1:0] rdData1,
    output logic [mipsPkg::DataWidth-1:0] rdData2
);
    import mipsPkg::*;

    logic [DataWidth-1:0]    regs [NumRegs];
    logic [RegAddrWidth-1:0] rdIdx1;
    logic [RegAddrWidth-1:0] wrIdx;

    // shifts take their source from rt
    assign rdIdx1 = ctrl.shiftUsesRt ? instr.rt : instr.rs;

    always_comb begin
        case (ctrl.destSel)
            destRd:   wrIdx = instr.rd;
            destLink: wrIdx = LinkReg;
            default:  wrIdx = instr.rt;
        endcase
    end

    // register 0 reads as zero
    assign rdData1 = (rdIdx1 == '0) ? '0 : regs[rdIdx1];
    assign rdData2 = (instr.rt == '0) ? '0 : regs[instr.rt];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule
